// ==== src.f ====
common/stream_pkg.sv
common/frame_pkg.sv
hw/frame_checker/frame_checker.sv
hw/frame_fifo/frame_fifo.sv
hw/frame_stats.sv
hw/frame_buffer_top.sv
sim/tb_frame_buffer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the frame buffer testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_frame_buffer -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile step failed"
    exit 1
fi

./obj_dir/Vtb_frame_buffer > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

// ==== sim/tb_frame_buffer.sv ====
// ==========================================================
// testbench for the receive frame buffer
// LFSR stimulus, expected-beat model, concurrent checks
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module tb_frame_buffer
    import stream_pkg::*, frame_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    // beats over all cases, case 2 counted at its longest frames
    localparam int TOTAL_BEATS = 10 * MAX_FRAME_BEATS + 75;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 400;

    logic                   clk = 1'b0;
    logic                   rst;
    beat_t                  s_beat;
    logic                   s_valid;
    beat_t                  m_beat;
    logic                   m_valid;
    logic                   m_ready;
    logic [COUNT_WIDTH-1:0] commit_count;
    logic [COUNT_WIDTH-1:0] bad_count;
    logic [COUNT_WIDTH-1:0] overflow_count;

    // expected output beats, written ahead, published at commit
    beat_t       exp_mem [256];
    int          exp_wr = 0;
    int          exp_rd;
    logic        head_valid;
    beat_t       head_beat;
    // expected counter values
    int          exp_commit = 0;
    int          exp_bad = 0;
    int          exp_ovf = 0;
    // beats kept since m_ready went low
    int          held_beats = 0;
    // m_ready: 0 held low, 1 held high, 2 random
    int          ready_mode = 1;
    logic        cnt_chk;
    logic [15:0] lfsr;
    int          err_count = 0;
    int          case_num = 0;
    int          case_fails = 0;
    int          case_err_start = 0;

    frame_buffer_top i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign head_valid = (exp_rd != exp_wr);
    assign head_beat  = exp_mem[exp_rd[7:0]];

    // one expected beat leaves per transfer
    always @(posedge clk) begin
        if (rst) begin
            exp_rd <= 0;
        end else if (m_valid && m_ready && head_valid) begin
            exp_rd <= exp_rd + 1;
        end
    end

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("** Error at time %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        err_count++;
    endtask

    task automatic fault(input string what);
        $display("Error at time %0t: %s", $time, what);
        err_count++;
    endtask

    // one clock, inputs change 2 ns after the edge
    task automatic tick(input logic valid, input beat_t beat);
        logic [15:0] r;
        @(posedge clk);
        #2;
        s_valid = valid;
        s_beat  = beat;
        if (ready_mode == 2) begin
            take_bits(1, r);
            m_ready = r[0];
        end else begin
            m_ready = (ready_mode == 1);
        end
    endtask

    task automatic send_frame(input int len, input logic src_err);
        beat_t       b;
        logic [15:0] r;
        logic        bad;
        logic        drop;
        bad  = src_err || len < MIN_FRAME_BEATS || len > MAX_FRAME_BEATS;
        // output held, so one kept beat sits in the output register
        drop = !bad && ready_mode == 0 &&
               (held_beats - (held_beats > 0 ? 1 : 0) + len > FIFO_DEPTH);
        for (int i = 0; i < len; i++) begin
            take_bits(DATA_WIDTH, r);
            b.data = r[DATA_WIDTH-1:0];
            b.last = (i == len - 1);
            b.user = 1'b0;
            exp_mem[8'(exp_wr + i)] = b;
            b.user = b.last & src_err;
            tick(1'b1, b);
        end
        if (bad) begin
            exp_bad++;
        end else if (drop) begin
            exp_ovf++;
        end else begin
            exp_commit++;
            held_beats += len;
            exp_wr += len;
        end
    endtask

    // keep backlog small while m_ready is random, no overflow there
    task automatic wait_room();
        while (exp_wr - exp_rd > 3) tick(1'b0, '0);
    endtask

    task automatic drain();
        // counters settle three cycles after the last input beat
        repeat (3) tick(1'b0, '0);
        while (head_valid) tick(1'b0, '0);
    endtask

    task automatic start_case();
        case_num++;
        case_err_start = err_count;
    endtask

    task automatic finish_case(input string name);
        int errs;
        drain();
        tick(1'b0, '0);
        cnt_chk = 1'b1;
        tick(1'b0, '0);
        cnt_chk = 1'b0;
        errs = err_count - case_err_start;
        if (errs == 0) begin
            $display("case %0d, %s: ok", case_num, name);
        end else begin
            $display("case %0d, %s: %0d errors", case_num, name, errs);
            case_fails++;
        end
    endtask

    // output only when a beat is expected, and the right one
    a_no_extra: assert property (@(posedge clk) disable iff (rst) m_valid |-> head_valid)
        else fault("m_valid high while no frame beat is expected");
    a_beat_match: assert property (@(posedge clk) disable iff (rst)
        m_valid && m_ready && head_valid |-> m_beat == head_beat)
        else value_error("m_beat", 32'($sampled(m_beat)), 32'($sampled(head_beat)));

    // counters against the model on request
    a_commit_count: assert property (@(posedge clk)
        cnt_chk |-> commit_count == COUNT_WIDTH'(exp_commit))
        else value_error("commit_count", 32'($sampled(commit_count)), exp_commit);
    a_bad_count: assert property (@(posedge clk)
        cnt_chk |-> bad_count == COUNT_WIDTH'(exp_bad))
        else value_error("bad_count", 32'($sampled(bad_count)), exp_bad);
    a_overflow_count: assert property (@(posedge clk)
        cnt_chk |-> overflow_count == COUNT_WIDTH'(exp_ovf))
        else value_error("overflow_count", 32'($sampled(overflow_count)), exp_ovf);

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the last case finished");
        $display("test failed");
        $finish;
    end

    initial begin
        logic [15:0] r;
        rst     = 1'b1;
        s_valid = 1'b0;
        s_beat  = '0;
        m_ready = 1'b0;
        cnt_chk = 1'b0;
        lfsr    = 16'd18651;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        start_case();
        finish_case("reset state");

        // legal lengths, random m_ready
        start_case();
        ready_mode = 2;
        for (int f = 0; f < 10; f++) begin
            take_bits(4, r);
            wait_room();
            send_frame(4 + (int'(r) % 9), 1'b0);
        end
        finish_case("legal frames");

        start_case();
        send_frame(5, 1'b0);
        wait_room();
        send_frame(6, 1'b1);
        send_frame(7, 1'b0);
        finish_case("source error");

        start_case();
        send_frame(8, 1'b0);
        wait_room();
        send_frame(3, 1'b0);
        send_frame(13, 1'b0);
        send_frame(9, 1'b0);
        finish_case("length limits");

        // output held from an empty FIFO, third frame overflows
        start_case();
        ready_mode = 0;
        held_beats = 0;
        repeat (3) send_frame(6, 1'b0);
        ready_mode = 1;
        drain();
        send_frame(6, 1'b0);
        finish_case("overflow");

        $display("summary: %0d cases, %0d failing, %0d errors", case_num, case_fails, err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/frame_buffer_top.sv ====
// ==========================================================
// receive frame buffer top level
// checker into frame FIFO, outcomes into statistics
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module frame_buffer_top
    import stream_pkg::*, frame_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  beat_t                  s_beat,
    input  logic                   s_valid,
    output beat_t                  m_beat,
    output logic                   m_valid,
    input  logic                   m_ready,
    output logic [COUNT_WIDTH-1:0] commit_count,
    output logic [COUNT_WIDTH-1:0] bad_count,
    output logic [COUNT_WIDTH-1:0] overflow_count
);

    // checked beats, user holds the discard verdict
    beat_t          chk_beat;
    logic           chk_valid;
    // per-frame result from the FIFO
    frame_outcome_t outcome;
    logic           outcome_valid;

    frame_checker i_checker (
        .clk       (clk),
        .rst       (rst),
        .s_beat    (s_beat),
        .s_valid   (s_valid),
        .chk_beat  (chk_beat),
        .chk_valid (chk_valid)
    );

    // input side cannot stall, FIFO drops what does not fit
    frame_fifo i_fifo (
        .clk           (clk),
        .rst           (rst),
        .chk_beat      (chk_beat),
        .chk_valid     (chk_valid),
        .m_beat        (m_beat),
        .m_valid       (m_valid),
        .m_ready       (m_ready),
        .outcome       (outcome),
        .outcome_valid (outcome_valid)
    );

    frame_stats i_stats (
        .clk            (clk),
        .rst            (rst),
        .outcome        (outcome),
        .outcome_valid  (outcome_valid),
        .commit_count   (commit_count),
        .bad_count      (bad_count),
        .overflow_count (overflow_count)
    );

endmodule

`default_nettype wire

// ==== hw/frame_stats.sv ====
// ==========================================================
// frame statistics
// saturating counters of committed, bad and overflowed frames
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module frame_stats
    import frame_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  frame_outcome_t         outcome,
    input  logic                   outcome_valid,
    output logic [COUNT_WIDTH-1:0] commit_count,
    output logic [COUNT_WIDTH-1:0] bad_count,
    output logic [COUNT_WIDTH-1:0] overflow_count
);

    // increment that sticks at all ones
    function automatic logic [COUNT_WIDTH-1:0] sat_inc(input logic [COUNT_WIDTH-1:0] value);
        sat_inc = (&value) ? value : value + 1'b1;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_count   <= '0;
            bad_count      <= '0;
            overflow_count <= '0;
        end else if (outcome_valid) begin
            // one counter per outcome
            case (outcome)
                OUT_COMMIT:   commit_count   <= sat_inc(commit_count);
                OUT_BAD:      bad_count      <= sat_inc(bad_count);
                OUT_OVERFLOW: overflow_count <= sat_inc(overflow_count);
                default:      begin
                    // unused encoding, counters hold
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/frame_fifo/frame_fifo.sv ====
// ==========================================================
// store-and-forward frame FIFO
// commit or rollback per frame, drop on overflow,
// one-entry registered output stage
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module frame_fifo
    import stream_pkg::*, frame_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  beat_t          chk_beat,
    input  logic           chk_valid,
    output beat_t          m_beat,
    output logic           m_valid,
    input  logic           m_ready,
    output frame_outcome_t outcome,
    output logic           outcome_valid
);

    // pointers carry one wrap bit above the address
    logic [FIFO_ADDR_WIDTH:0]   wr_ptr;
    logic [FIFO_ADDR_WIDTH:0]   wr_ptr_cur;
    logic [FIFO_ADDR_WIDTH:0]   rd_ptr;
    // set once the frame in progress ran into a full memory
    logic                       drop_frame;

    beat_t                      mem [FIFO_DEPTH];

    logic                       full;
    logic                       empty;
    logic                       drop_beat;
    logic                       read;

    // full counts committed unread beats plus the open frame
    assign full = (wr_ptr_cur[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
                  (wr_ptr_cur[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);
    // only committed beats are visible to the read side
    assign empty = (wr_ptr == rd_ptr);

    // a beat is thrown away if memory is full or the frame is already lost
    assign drop_beat = full | drop_frame;

    // refill output stage when it is empty or being taken
    assign read = ~empty & (m_ready | ~m_valid);

    // write side pointers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            wr_ptr_cur <= '0;
            drop_frame <= 1'b0;
        end else if (chk_valid) begin
            if (drop_beat) begin
                drop_frame <= 1'b1;
                if (chk_beat.last) begin
                    // overflowed frame, forget its partial beats
                    wr_ptr_cur <= wr_ptr;
                    drop_frame <= 1'b0;
                end
            end else begin
                wr_ptr_cur <= wr_ptr_cur + 1'b1;
                if (chk_beat.last) begin
                    if (chk_beat.user) begin
                        // bad frame, rollback
                        wr_ptr_cur <= wr_ptr;
                    end else begin
                        // good frame, publish to the read side
                        wr_ptr <= wr_ptr_cur + 1'b1;
                    end
                end
            end
        end
    end

    // frame memory, user is not stored
    always_ff @(posedge clk) begin
        if (chk_valid && !drop_beat) begin
            mem[wr_ptr_cur[FIFO_ADDR_WIDTH-1:0]] <= '{
                data: chk_beat.data,
                last: chk_beat.last,
                user: 1'b0
            };
        end
    end

    // outcome strobe, one pulse per last beat
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outcome_valid <= 1'b0;
        end else begin
            outcome_valid <= chk_valid & chk_beat.last;
        end
    end

    // overflow wins over a bad mark
    always_ff @(posedge clk) begin
        if (chk_valid && chk_beat.last) begin
            if (drop_beat) begin
                outcome <= OUT_OVERFLOW;
            end else if (chk_beat.user) begin
                outcome <= OUT_BAD;
            end else begin
                outcome <= OUT_COMMIT;
            end
        end
    end

    // read pointer and output valid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr  <= '0;
            m_valid <= 1'b0;
        end else begin
            if (read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (m_ready || !m_valid) begin
                m_valid <= ~empty;
            end
        end
    end

    // output data register
    always_ff @(posedge clk) begin
        if (read) begin
            m_beat <= mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
        end
    end

    // read side stays behind the committed pointer
    a_rd_behind_commit: assert property (@(posedge clk) disable iff (rst)
        (wr_ptr - rd_ptr) <= (FIFO_ADDR_WIDTH + 1)'(FIFO_DEPTH));

    // held beat does not change under back-pressure
    a_out_stable: assert property (@(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(m_beat));

endmodule

`default_nettype wire

// ==== hw/frame_checker/frame_checker.sv ====
// ==========================================================
// frame checker
// counts beats per frame, flags short, long and source-flagged
// frames on their last beat, one cycle of latency
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module frame_checker
    import stream_pkg::*, frame_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  beat_t s_beat,
    input  logic  s_valid,
    output beat_t chk_beat,
    output logic  chk_valid
);

    chk_state_t                state;
    // beats already seen in the current frame
    logic [BEAT_CNT_WIDTH-1:0] beat_cnt;
    // position of the incoming beat, counting from one
    logic [BEAT_CNT_WIDTH-1:0] beat_num;
    logic                      too_short;
    logic                      too_long;
    logic                      discard;

    assign beat_num  = beat_cnt + 1'b1;
    assign too_short = beat_num < BEAT_CNT_WIDTH'(MIN_FRAME_BEATS);
    // long either because the counter already stopped or this beat passes max
    assign too_long  = (state == CHK_LONG) ||
                       (beat_num > BEAT_CNT_WIDTH'(MAX_FRAME_BEATS));
    // discard flag only carries meaning on the last beat
    assign discard   = s_beat.last & (s_beat.user | too_short | too_long);

    // length tracking
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= CHK_IDLE;
            beat_cnt <= '0;
        end else if (s_valid) begin
            if (s_beat.last) begin
                // frame done, next beat starts a new one
                state    <= CHK_IDLE;
                beat_cnt <= '0;
            end else if (state == CHK_LONG) begin
                // counter frozen until the last beat
                state    <= CHK_LONG;
            end else if (beat_num > BEAT_CNT_WIDTH'(MAX_FRAME_BEATS)) begin
                state    <= CHK_LONG;
                beat_cnt <= beat_num;
            end else begin
                state    <= CHK_BODY;
                beat_cnt <= beat_num;
            end
        end
    end

    // strobe register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            chk_valid <= 1'b0;
        end else begin
            chk_valid <= s_valid;
        end
    end

    // beat register, user replaced by the discard verdict
    always_ff @(posedge clk) begin
        if (s_valid) begin
            chk_beat.data <= s_beat.data;
            chk_beat.last <= s_beat.last;
            chk_beat.user <= discard;
        end
    end

    // nothing may leave the checker right after reset
    a_no_valid_after_rst: assert property (@(posedge clk) rst |=> !chk_valid);

endmodule

`default_nettype wire

// ==== common/frame_pkg.sv ====
// ==========================================================
// frame level definitions
// length limits, checker states, frame outcomes, counter width
// ==========================================================
`default_nettype none

package frame_pkg;

    // legal frame length range in beats, inclusive
    localparam int unsigned MIN_FRAME_BEATS = 4;
    localparam int unsigned MAX_FRAME_BEATS = 12;

    // beat counter wide enough for max length plus one
    localparam int unsigned BEAT_CNT_WIDTH = $clog2(MAX_FRAME_BEATS + 2);

    // statistics counter width
    localparam int unsigned COUNT_WIDTH = 16;

    // frame checker states
    typedef enum logic [1:0] {
        CHK_IDLE,
        CHK_BODY,
        CHK_LONG
    } chk_state_t;

    // what happened to a frame at its last beat
    typedef enum logic [1:0] {
        OUT_COMMIT,
        OUT_BAD,
        OUT_OVERFLOW
    } frame_outcome_t;

endpackage

`default_nettype wire

// ==== common/stream_pkg.sv ====
// ==========================================================
// stream types shared by the frame buffer
// beat struct, data width and FIFO sizing
// ==========================================================
`default_nettype none

package stream_pkg;

    // width of one data beat
    localparam int unsigned DATA_WIDTH = 8;

    // FIFO memory sizing, depth is a power of two
    localparam int unsigned FIFO_ADDR_WIDTH = 4;
    localparam int unsigned FIFO_DEPTH      = 2 ** FIFO_ADDR_WIDTH;

    // one beat of a frame
    typedef struct packed {
        // payload byte
        logic [DATA_WIDTH-1:0] data;
        // final beat of a frame
        logic                  last;
        // error or discard flag, only looked at together with last
        logic                  user;
    } beat_t;

endpackage

`default_nettype wire
